// File: src/mcd_settings.svh
// Constants shared by the host glue RTL and its testbench
// Stretch length must be a power of two since the counters wrap at zero
// Index classes compare against the low six download index bits only
`ifndef MCD_SETTINGS_SVH
`define MCD_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// CD drive link and stretch
////////////////////////////////////////////////////////////////////////////

// Status and command payload
`define MCD_CDD_PAYLOAD_W 40
// Receive pulse and CDC write strobe length in clk_sys cycles
`define MCD_STRETCH_CYCLES 8

////////////////////////////////////////////////////////////////////////////
// Cartridge header and download classes
////////////////////////////////////////////////////////////////////////////

// Region byte position in the cartridge header
`define MCD_HDR_REGION_ADDR 25'h1F0
`define MCD_HDR_CHAR_J 8'h4A
`define MCD_HDR_CHAR_U 8'h55

// Index 0 and 1 are both cartridge loads
`define MCD_IDX_CART_MAX 6'h01
`define MCD_IDX_CDC_DAT 6'h02
`define MCD_IDX_CDC_SUB 6'h03

////////////////////////////////////////////////////////////////////////////
// Keyboard codes and region codes
////////////////////////////////////////////////////////////////////////////

// Enter and Esc match on the low byte only
`define MCD_KEY_ENTER 8'h5A
`define MCD_KEY_ESC 8'h76
`define MCD_KEY_F1 9'h005
`define MCD_KEY_F2 9'h006
`define MCD_KEY_F3 9'h004

`define MCD_REGION_JP 2'd0
`define MCD_REGION_US 2'd1
`define MCD_REGION_EU 2'd2

`endif

// File: src/mcd_pkg.sv
// Types shared by the host glue blocks
// Struct fields are listed MSB first and follow the host bus bit layout
// The key_region_t pulse field is named evt

`include "mcd_settings.svh"

package mcd_pkg;

	// Region code as carried in the core status word
	typedef logic [1:0] region_t;

	// Drive status or command record
	typedef logic [`MCD_CDD_PAYLOAD_W-1:0] cdd_payload_t;

	// Host keyboard word, strobe flips once per key event
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// Host to core drive status
	typedef struct packed {
		logic         toggle;
		logic [6:0]   spare;
		logic         dm;
		cdd_payload_t stat;
	} cdd_from_host_t;

	// Core to host drive command
	typedef struct packed {
		logic         toggle;
		logic [7:0]   pad;
		cdd_payload_t comm;
	} cdd_to_host_t;

	// Host download port
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
	} host_load_t;

	// Region request towards the core status word
	typedef struct packed {
		logic    set;
		region_t region;
	} region_req_t;

	// Region key event, evt is a one cycle pulse
	typedef struct packed {
		logic    evt;
		logic    set;
		region_t region;
	} key_region_t;

endpackage

// File: src/cdd_link.sv
// CD drive status and command link to the host
// Each direction signals a new record by flipping its toggle bit
// Status payload and command word are held until the next record
`timescale 1ns/100ps
`include "mcd_settings.svh"

module cdd_link (
	input  logic                    clk_sys,
	input  logic                    reset_i,
	input  mcd_pkg::cdd_from_host_t cd_from_host_i,
	output mcd_pkg::cdd_to_host_t   cd_to_host_o,
	input  mcd_pkg::cdd_payload_t   cdd_comm_i,
	input  logic                    cdd_send_i,
	output mcd_pkg::cdd_payload_t   cdd_stat_o,
	output logic                    cdd_dm_o,
	output logic                    cdd_rec_o
);
	import mcd_pkg::*;

	localparam int CNT_W = $clog2(`MCD_STRETCH_CYCLES);

	// Receive side
	logic             tgl_seen;
	logic             rec_hit;
	logic [CNT_W-1:0] rec_cnt;

	// Send side
	logic             send_old;
	logic             send_rise;
	logic             tgl_out;
	cdd_payload_t     comm_q;

	////////////////////////////////////////////////////////////////////////////
	// Host to core status
	////////////////////////////////////////////////////////////////////////////

	// New record whenever host toggle differs from last one seen
	assign rec_hit = cd_from_host_i.toggle != tgl_seen;

	// Pulse restarts on every new record
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			tgl_seen  <= 1'b1;
			rec_cnt   <= '0;
			cdd_rec_o <= 1'b0;
		end else if (rec_hit) begin
			tgl_seen  <= cd_from_host_i.toggle;
			rec_cnt   <= CNT_W'(`MCD_STRETCH_CYCLES - 1);
			cdd_rec_o <= 1'b1;
		end else if (rec_cnt != '0) begin
			rec_cnt <= rec_cnt - 1'b1;
		end else begin
			// Counter ran out, drop the pulse
			cdd_rec_o <= 1'b0;
		end
	end

	// Status record and data mode
	always_ff @(posedge clk_sys) begin
		if (rec_hit) begin
			cdd_stat_o <= cd_from_host_i.stat;
			cdd_dm_o   <= cd_from_host_i.dm;
		end
		if (send_rise) begin
			comm_q <= cdd_comm_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Core to host command
	////////////////////////////////////////////////////////////////////////////

	// Rising edge of the core send strobe
	assign send_rise = cdd_send_i & ~send_old;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			send_old <= 1'b0;
			tgl_out  <= 1'b0;
		end else begin
			send_old <= cdd_send_i;
			if (send_rise) begin
				tgl_out <= ~tgl_out;
			end
		end
	end

	// Pad byte always zero
	assign cd_to_host_o = '{toggle: tgl_out, pad: 8'h00, comm: comm_q};

endmodule

// File: src/cdc_feed.sv
// CD data and subcode feed from the host download port
// Each matching write becomes an eight cycle strobe for the CD controller
// Writes to other download classes are ignored
`timescale 1ns/100ps
`include "mcd_settings.svh"

module cdc_feed (
	input  logic                clk_sys,
	input  logic                reset_i,
	input  mcd_pkg::host_load_t load_i,
	output logic [15:0]         cdc_data_o,
	output logic                cdc_dat_wr_o,
	output logic                cdc_sc_wr_o
);
	localparam int CNT_W = $clog2(`MCD_STRETCH_CYCLES);

	logic             is_dat;
	logic             is_sub;
	logic             wr_hit;
	logic             wr_act;
	logic             sel_sub;
	logic [CNT_W-1:0] wr_cnt;

	// Download class decode
	assign is_dat = load_i.download & (load_i.index[5:0] == `MCD_IDX_CDC_DAT);
	assign is_sub = load_i.download & (load_i.index[5:0] == `MCD_IDX_CDC_SUB);
	assign wr_hit = load_i.wr & (is_dat | is_sub);

	// Stretch counter, a new write restarts it
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			wr_act  <= 1'b0;
			sel_sub <= 1'b0;
			wr_cnt  <= '0;
		end else if (wr_hit) begin
			wr_act  <= 1'b1;
			sel_sub <= is_sub;
			wr_cnt  <= CNT_W'(`MCD_STRETCH_CYCLES - 1);
		end else if (wr_cnt != '0) begin
			wr_cnt <= wr_cnt - 1'b1;
		end else begin
			wr_act <= 1'b0;
		end
	end

	// Write data
	always_ff @(posedge clk_sys) begin
		if (wr_hit) begin
			cdc_data_o <= load_i.data;
		end
	end

	// Strobe goes to the latched class only
	assign cdc_dat_wr_o = wr_act & ~sel_sub;
	assign cdc_sc_wr_o  = wr_act & sel_sub;

endmodule

// File: src/kbd_hotkeys.sv
// Keyboard hotkeys from the host key word
// Enter plus Esc flips the debug menu flag, F1 F2 F3 request a region
// Enter and Esc match on the low code byte, so keypad Enter counts too
`timescale 1ns/100ps
`include "mcd_settings.svh"

module kbd_hotkeys (
	input  logic                 clk_sys,
	input  logic                 reset_i,
	input  mcd_pkg::ps2_key_t    ps2_key_i,
	output logic                 dbg_menu_o,
	output mcd_pkg::key_region_t key_region_o
);
	import mcd_pkg::*;

	logic    stb_old;
	logic    stb_evt;
	logic    is_enter;
	logic    is_esc;
	logic    enter_held;
	logic    esc_held;
	logic    fkey_hit;
	region_t fkey_region;
	logic    key_evt;
	logic    key_set;
	region_t key_reg;

	// Last strobe level
	always_ff @(posedge clk_sys) begin
		stb_old <= ps2_key_i.strobe;
	end

	assign stb_evt  = stb_old ^ ps2_key_i.strobe;
	assign is_enter = ps2_key_i.code[7:0] == `MCD_KEY_ENTER;
	assign is_esc   = ps2_key_i.code[7:0] == `MCD_KEY_ESC;

	// Function key to region
	always_comb begin
		fkey_hit    = 1'b1;
		fkey_region = `MCD_REGION_JP;
		case (ps2_key_i.code)
			`MCD_KEY_F1: fkey_region = `MCD_REGION_JP;
			`MCD_KEY_F2: fkey_region = `MCD_REGION_US;
			`MCD_KEY_F3: fkey_region = `MCD_REGION_EU;
			default:     fkey_hit = 1'b0;
		endcase
	end

	// Held flags and debug menu toggle
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			enter_held <= 1'b0;
			esc_held   <= 1'b0;
			dbg_menu_o <= 1'b0;
		end else begin
			if (stb_evt && is_enter) enter_held <= ps2_key_i.pressed;
			if (stb_evt && is_esc)   esc_held   <= ps2_key_i.pressed;
			// Both down, flip once and rearm
			if (enter_held && esc_held) begin
				dbg_menu_o <= ~dbg_menu_o;
				enter_held <= 1'b0;
				esc_held   <= 1'b0;
			end
		end
	end

	// Region key event pulse
	always_ff @(posedge clk_sys) begin
		if (reset_i) key_evt <= 1'b0;
		else key_evt <= stb_evt & fkey_hit;
	end

	// Press level and region of the last function key
	always_ff @(posedge clk_sys) begin
		if (stb_evt && fkey_hit) begin
			key_set <= ps2_key_i.pressed;
			key_reg <= fkey_region;
		end
	end

	assign key_region_o = '{evt: key_evt, set: key_set, region: key_reg};

endmodule

// File: src/region_select.sv
// Region request from the cartridge header or the region keys
// Header region byte is sniffed while a cartridge is downloading
// Header result wins over a key event in the same cycle
`timescale 1ns/100ps
`include "mcd_settings.svh"

module region_select (
	input  logic                 clk_sys,
	input  logic                 reset_i,
	input  mcd_pkg::host_load_t  load_i,
	input  mcd_pkg::key_region_t key_region_i,
	output logic                 cart_loading_o,
	output mcd_pkg::region_req_t region_o
);
	import mcd_pkg::*;

	logic    cart_old;
	logic    cart_rise;
	logic    cart_fall;
	logic    hdr_hit;
	logic    hdr_j;
	logic    hdr_u;
	logic    hdr_ready;
	logic    ready_old;
	logic    ready_rise;
	logic    ready_fall;
	region_t hdr_region;

	////////////////////////////////////////////////////////////////////////////
	// Cartridge header sniffing
	////////////////////////////////////////////////////////////////////////////

	// Index 0 and 1 are cartridge loads
	assign cart_loading_o = load_i.download & (load_i.index[5:0] <= `MCD_IDX_CART_MAX);

	assign cart_rise = cart_loading_o & ~cart_old;
	assign cart_fall = ~cart_loading_o & cart_old;
	assign hdr_hit   = load_i.wr & cart_loading_o & (load_i.addr == `MCD_HDR_REGION_ADDR);

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			cart_old  <= 1'b0;
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			cart_old <= cart_loading_o;
			// Fresh download forgets the old header
			if (cart_rise) begin
				hdr_j     <= 1'b0;
				hdr_u     <= 1'b0;
				hdr_ready <= 1'b0;
			end
			if (cart_fall) hdr_ready <= 1'b0;
			if (hdr_hit) begin
				if (load_i.data[7:0] == `MCD_HDR_CHAR_J) hdr_j <= 1'b1;
				else if (load_i.data[7:0] == `MCD_HDR_CHAR_U) hdr_u <= 1'b1;
				hdr_ready <= 1'b1;
			end
		end
	end

	// US first, then JP, anything else is EU
	assign hdr_region = hdr_u ? `MCD_REGION_US : (hdr_j ? `MCD_REGION_JP : `MCD_REGION_EU);

	////////////////////////////////////////////////////////////////////////////
	// Request arbitration
	////////////////////////////////////////////////////////////////////////////

	assign ready_rise = hdr_ready & ~ready_old;
	assign ready_fall = ~hdr_ready & ready_old;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			ready_old <= 1'b0;
			region_o  <= '0;
		end else begin
			ready_old <= hdr_ready;
			if (key_region_i.evt) begin
				region_o.set    <= key_region_i.set;
				region_o.region <= key_region_i.region;
			end
			if (ready_rise) begin
				region_o.set    <= 1'b1;
				region_o.region <= hdr_region;
			end
			// Request released once the download is over
			if (ready_fall) region_o.set <= 1'b0;
		end
	end

endmodule

// File: src/mcd_host_glue.sv
// Host side glue of the CD console core
// All blocks run on clk_sys with a synchronous active high reset
// No back-pressure on any host or core path
`timescale 1ns/100ps

module mcd_host_glue (
	input  logic                    clk_sys,
	input  logic                    reset_i,
	// Host ports
	input  mcd_pkg::host_load_t     load_i,
	input  mcd_pkg::ps2_key_t       ps2_key_i,
	input  mcd_pkg::cdd_from_host_t cd_from_host_i,
	output mcd_pkg::cdd_to_host_t   cd_to_host_o,
	// Core drive interface
	input  mcd_pkg::cdd_payload_t   cdd_comm_i,
	input  logic                    cdd_send_i,
	output mcd_pkg::cdd_payload_t   cdd_stat_o,
	output logic                    cdd_dm_o,
	output logic                    cdd_rec_o,
	// Core CD controller feed
	output logic [15:0]             cdc_data_o,
	output logic                    cdc_dat_wr_o,
	output logic                    cdc_sc_wr_o,
	// Menu and region
	output logic                    dbg_menu_o,
	output logic                    cart_loading_o,
	output mcd_pkg::region_req_t    region_o
);
	import mcd_pkg::*;

	// Key events towards the region arbiter
	key_region_t key_region;

	cdd_link i_cdd_link (
		.clk_sys        (clk_sys),
		.reset_i        (reset_i),
		.cd_from_host_i (cd_from_host_i),
		.cd_to_host_o   (cd_to_host_o),
		.cdd_comm_i     (cdd_comm_i),
		.cdd_send_i     (cdd_send_i),
		.cdd_stat_o     (cdd_stat_o),
		.cdd_dm_o       (cdd_dm_o),
		.cdd_rec_o      (cdd_rec_o)
	);

	cdc_feed i_cdc_feed (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.load_i       (load_i),
		.cdc_data_o   (cdc_data_o),
		.cdc_dat_wr_o (cdc_dat_wr_o),
		.cdc_sc_wr_o  (cdc_sc_wr_o)
	);

	kbd_hotkeys i_kbd_hotkeys (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.ps2_key_i    (ps2_key_i),
		.dbg_menu_o   (dbg_menu_o),
		.key_region_o (key_region)
	);

	region_select i_region_select (
		.clk_sys        (clk_sys),
		.reset_i        (reset_i),
		.load_i         (load_i),
		.key_region_i   (key_region),
		.cart_loading_o (cart_loading_o),
		.region_o       (region_o)
	);

endmodule

// File: verification/tb_mcd_host_glue.sv
// Testbench for the host glue with random stimulus from a 16-bit LFSR
// Inputs change on the falling edge where outputs are also compared
// A cycle model predicts every output and the first mismatch stops the run
// Status, command and CDC data are compared only once a record exists
`timescale 1ns/100ps
`include "mcd_settings.svh"

module tb_mcd_host_glue;
	import mcd_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;
	localparam int N_STAT       = 400;
	localparam int N_CMD        = 300;
	localparam int N_CDC        = 400;
	localparam int N_KEY        = 400;
	localparam int N_FKEY       = 40;
	localparam int FKEY_MAX     = 10;
	localparam int N_CART       = 12;
	localparam int CART_MAX     = 32;
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_STAT + N_CMD + N_CDC + N_KEY
		+ N_FKEY * FKEY_MAX + N_CART * CART_MAX + 200;

	logic           clk_sys = 1'b0;
	logic           reset_i;
	host_load_t     load_i;
	ps2_key_t       ps2_key_i;
	cdd_from_host_t cd_from_host_i;
	cdd_to_host_t   cd_to_host_o;
	cdd_payload_t   cdd_comm_i;
	logic           cdd_send_i;
	cdd_payload_t   cdd_stat_o;
	logic           cdd_dm_o;
	logic           cdd_rec_o;
	logic [15:0]    cdc_data_o;
	logic           cdc_dat_wr_o;
	logic           cdc_sc_wr_o;
	logic           dbg_menu_o;
	logic           cart_loading_o;
	region_req_t    region_o;

	logic [15:0] lfsr_q = 16'd17552;

	// Model state of the drive link
	logic         tgl_seen_m;
	int           rec_rem;
	cdd_payload_t stat_m;
	logic         dm_m;
	logic         stat_ok;
	logic         send_old_m;
	logic         tgl_out_m;
	cdd_payload_t comm_m;
	logic         comm_ok;
	// Model state of the CDC feed
	int           wr_rem;
	logic         sub_m;
	logic [15:0]  data_m;
	logic         data_ok;
	// Model state of keyboard and region
	logic         stb_old_m = 1'b0;
	logic         enter_m;
	logic         esc_m;
	logic         dbg_m;
	logic         kevt_m;
	logic         kset_m;
	region_t      kreg_m;
	logic         cart_old_m;
	logic         hj_m;
	logic         hu_m;
	logic         ready_m;
	logic         ready_old_m;
	logic         reg_set_m;
	region_t      reg_m;

	mcd_host_glue i_mcd_host_glue (
		.clk_sys        (clk_sys),
		.reset_i        (reset_i),
		.load_i         (load_i),
		.ps2_key_i      (ps2_key_i),
		.cd_from_host_i (cd_from_host_i),
		.cd_to_host_o   (cd_to_host_o),
		.cdd_comm_i     (cdd_comm_i),
		.cdd_send_i     (cdd_send_i),
		.cdd_stat_o     (cdd_stat_o),
		.cdd_dm_o       (cdd_dm_o),
		.cdd_rec_o      (cdd_rec_o),
		.cdc_data_o     (cdc_data_o),
		.cdc_dat_wr_o   (cdc_dat_wr_o),
		.cdc_sc_wr_o    (cdc_sc_wr_o),
		.dbg_menu_o     (dbg_menu_o),
		.cart_loading_o (cart_loading_o),
		.region_o       (region_o)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 16 14 13 11 and one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			val = {val[62:0], fb};
		end
		return val;
	endfunction

	// Index 0 and 1 are cartridge loads
	function automatic logic is_cart(input host_load_t ld);
		return ld.download && (ld.index[5:0] <= `MCD_IDX_CART_MAX);
	endfunction

	function automatic logic fkey_valid(input logic [8:0] code);
		return code == `MCD_KEY_F1 || code == `MCD_KEY_F2 || code == `MCD_KEY_F3;
	endfunction

	// F1 Japan, F2 US, F3 Europe
	function automatic region_t fkey_map(input logic [8:0] code);
		if (code == `MCD_KEY_F2) begin
			return `MCD_REGION_US;
		end else if (code == `MCD_KEY_F3) begin
			return `MCD_REGION_EU;
		end
		return `MCD_REGION_JP;
	endfunction

	// Header letter to region where unknown letters mean Europe
	function automatic region_t hdr_expect(input logic [7:0] letter);
		if (letter == `MCD_HDR_CHAR_U) begin
			return `MCD_REGION_US;
		end else if (letter == `MCD_HDR_CHAR_J) begin
			return `MCD_REGION_JP;
		end
		return `MCD_REGION_EU;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_outputs();
		check(64'(cdd_rec_o), 64'(rec_rem != 0), "cdd_rec_o pulse");
		if (stat_ok) begin
			check(64'(cdd_stat_o), 64'(stat_m), "cdd_stat_o record");
			check(64'(cdd_dm_o), 64'(dm_m), "cdd_dm_o data mode");
		end
		check(64'(cd_to_host_o.toggle), 64'(tgl_out_m), "command toggle");
		check(64'(cd_to_host_o.pad), 64'd0, "command pad byte");
		if (comm_ok) begin
			check(64'(cd_to_host_o.comm), 64'(comm_m), "command word");
		end
		check(64'(cdc_dat_wr_o), 64'(wr_rem != 0 && !sub_m), "cdc_dat_wr_o strobe");
		check(64'(cdc_sc_wr_o), 64'(wr_rem != 0 && sub_m), "cdc_sc_wr_o strobe");
		if (data_ok) begin
			check(64'(cdc_data_o), 64'(data_m), "cdc_data_o word");
		end
		check(64'(dbg_menu_o), 64'(dbg_m), "dbg_menu_o flag");
		check(64'(cart_loading_o), 64'(is_cart(load_i)), "cart_loading_o decode");
		check(64'(region_o.set), 64'(reg_set_m), "region_o.set");
		check(64'(region_o.region), 64'(reg_m), "region_o.region");
	endtask

	// Wait for the falling edge and compare before the caller drives
	task automatic next_cycle();
		@(negedge clk_sys);
		if (!reset_i) begin
			check_outputs();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cycle model
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin : model
		logic stb_evt;
		logic cart_now;
		logic dat_cls;
		logic sub_cls;
		stb_evt  = stb_old_m ^ ps2_key_i.strobe;
		cart_now = is_cart(load_i);
		dat_cls  = load_i.download && load_i.index[5:0] == `MCD_IDX_CDC_DAT;
		sub_cls  = load_i.download && load_i.index[5:0] == `MCD_IDX_CDC_SUB;

		// Keyboard strobe history and last function key
		stb_old_m <= ps2_key_i.strobe;
		if (stb_evt && fkey_valid(ps2_key_i.code)) begin
			kset_m <= ps2_key_i.pressed;
			kreg_m <= fkey_map(ps2_key_i.code);
		end

		if (reset_i) begin
			tgl_seen_m  <= 1'b1;
			rec_rem     <= 0;
			stat_ok     <= 1'b0;
			send_old_m  <= 1'b0;
			tgl_out_m   <= 1'b0;
			comm_ok     <= 1'b0;
			wr_rem      <= 0;
			sub_m       <= 1'b0;
			data_ok     <= 1'b0;
			enter_m     <= 1'b0;
			esc_m       <= 1'b0;
			dbg_m       <= 1'b0;
			kevt_m      <= 1'b0;
			cart_old_m  <= 1'b0;
			hj_m        <= 1'b0;
			hu_m        <= 1'b0;
			ready_m     <= 1'b0;
			ready_old_m <= 1'b0;
			reg_set_m   <= 1'b0;
			reg_m       <= `MCD_REGION_JP;
		end else begin
			// New status record on any toggle change restarts the pulse
			if (cd_from_host_i.toggle != tgl_seen_m) begin
				tgl_seen_m <= cd_from_host_i.toggle;
				stat_m     <= cd_from_host_i.stat;
				dm_m       <= cd_from_host_i.dm;
				stat_ok    <= 1'b1;
				rec_rem    <= `MCD_STRETCH_CYCLES;
			end else if (rec_rem != 0) begin
				rec_rem <= rec_rem - 1;
			end
			// One command per rising send edge
			send_old_m <= cdd_send_i;
			if (cdd_send_i && !send_old_m) begin
				tgl_out_m <= ~tgl_out_m;
				comm_m    <= cdd_comm_i;
				comm_ok   <= 1'b1;
			end
			// CDC write stretch
			if (load_i.wr && (dat_cls || sub_cls)) begin
				wr_rem  <= `MCD_STRETCH_CYCLES;
				sub_m   <= sub_cls;
				data_m  <= load_i.data;
				data_ok <= 1'b1;
			end else if (wr_rem != 0) begin
				wr_rem <= wr_rem - 1;
			end
			// Enter and Esc held flags
			if (stb_evt && ps2_key_i.code[7:0] == `MCD_KEY_ENTER) begin
				enter_m <= ps2_key_i.pressed;
			end
			if (stb_evt && ps2_key_i.code[7:0] == `MCD_KEY_ESC) begin
				esc_m <= ps2_key_i.pressed;
			end
			if (enter_m && esc_m) begin
				dbg_m   <= ~dbg_m;
				enter_m <= 1'b0;
				esc_m   <= 1'b0;
			end
			kevt_m <= stb_evt && fkey_valid(ps2_key_i.code);
			// Header sniffing where download edges clear ready
			cart_old_m <= cart_now;
			if (cart_now && !cart_old_m) begin
				hj_m    <= 1'b0;
				hu_m    <= 1'b0;
				ready_m <= 1'b0;
			end
			if (!cart_now && cart_old_m) begin
				ready_m <= 1'b0;
			end
			if (load_i.wr && cart_now && load_i.addr == `MCD_HDR_REGION_ADDR) begin
				if (load_i.data[7:0] == `MCD_HDR_CHAR_J) begin
					hj_m <= 1'b1;
				end else if (load_i.data[7:0] == `MCD_HDR_CHAR_U) begin
					hu_m <= 1'b1;
				end
				ready_m <= 1'b1;
			end
			// Key request first and a header edge overrides it
			ready_old_m <= ready_m;
			if (kevt_m) begin
				reg_set_m <= kset_m;
				reg_m     <= kreg_m;
			end
			if (ready_m && !ready_old_m) begin
				reg_set_m <= 1'b1;
				reg_m     <= hu_m ? `MCD_REGION_US : (hj_m ? `MCD_REGION_JP : `MCD_REGION_EU);
			end
			if (!ready_m && ready_old_m) begin
				reg_set_m <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [3:0]  gap;
		logic [7:0]  letter;
		logic [63:0] r;
		region_t     exp_region;
		int          n_wr;
		int          hdr_pos;
		int          idle;
		reset_i               = 1'b1;
		load_i                = '0;
		ps2_key_i             = '0;
		cd_from_host_i        = '0;
		cd_from_host_i.toggle = 1'b1;
		cdd_comm_i            = '0;
		cdd_send_i            = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset_i = 1'b0;

		// Status records where gaps under eight hit an active pulse
		gap = 4'd0;
		for (int i = 0; i < N_STAT; i++) begin
			next_cycle();
			if (gap == 4'd0) begin
				cd_from_host_i.toggle = ~cd_from_host_i.toggle;
				cd_from_host_i.spare  = 7'(rand_bits(7));
				cd_from_host_i.dm     = 1'(rand_bits(1));
				cd_from_host_i.stat   = 40'(rand_bits(40));
				gap = 4'(rand_bits(4));
			end else begin
				gap = gap - 4'd1;
			end
		end

		// Commands
		for (int i = 0; i < N_CMD; i++) begin
			next_cycle();
			cdd_send_i = 1'(rand_bits(1));
			cdd_comm_i = 40'(rand_bits(40));
		end
		next_cycle();
		cdd_send_i = 1'b0;

		// Download writes over indexes 0 to 5 with random upper index bits
		load_i.download = 1'b1;
		for (int i = 0; i < N_CDC; i++) begin
			next_cycle();
			r = rand_bits(3);
			load_i.index = {2'(rand_bits(2)), 6'(r % 64'd6)};
			load_i.wr    = rand_bits(2) == 64'd0;
			load_i.addr  = 25'(rand_bits(25));
			load_i.data  = 16'(rand_bits(16));
		end
		next_cycle();
		load_i = '0;

		// Enter, Esc, extended Enter and random codes
		for (int i = 0; i < N_KEY; i++) begin
			next_cycle();
			if (rand_bits(2) == 64'd0) begin
				r = rand_bits(2);
				case (r[1:0])
					2'd0: ps2_key_i.code = {1'b0, `MCD_KEY_ENTER};
					2'd1: ps2_key_i.code = {1'b0, `MCD_KEY_ESC};
					2'd2: ps2_key_i.code = {1'b1, `MCD_KEY_ENTER};
					default: ps2_key_i.code = 9'(rand_bits(9));
				endcase
				ps2_key_i.pressed = rand_bits(2) != 64'd0;
				ps2_key_i.strobe  = ~ps2_key_i.strobe;
			end
		end

		// Region keys with the result due two falling edges after the strobe change
		for (int i = 0; i < N_FKEY; i++) begin
			next_cycle();
			r = rand_bits(2);
			case (r[1:0])
				2'd0: ps2_key_i.code = `MCD_KEY_F1;
				2'd1: ps2_key_i.code = `MCD_KEY_F2;
				default: ps2_key_i.code = `MCD_KEY_F3;
			endcase
			ps2_key_i.pressed = 1'(rand_bits(1));
			ps2_key_i.strobe  = ~ps2_key_i.strobe;
			next_cycle();
			next_cycle();
			check(64'(region_o.set), 64'(ps2_key_i.pressed), "region key press level");
			check(64'(region_o.region), 64'(fkey_map(ps2_key_i.code)), "region key mapping");
			idle = int'(rand_bits(3));
			repeat (idle) next_cycle();
		end

		// Cartridge downloads with one header region write each
		for (int c = 0; c < N_CART; c++) begin
			next_cycle();
			load_i.download = 1'b1;
			load_i.index    = {2'(rand_bits(2)), 5'd0, 1'(rand_bits(1))};
			r = rand_bits(2);
			case (r[1:0])
				2'd0: letter = `MCD_HDR_CHAR_J;
				2'd1: letter = `MCD_HDR_CHAR_U;
				default: begin
					letter = 8'h41 + 8'(rand_bits(8) % 64'd26);
					if (letter == `MCD_HDR_CHAR_J || letter == `MCD_HDR_CHAR_U) begin
						letter = 8'h45;
					end
				end
			endcase
			exp_region = hdr_expect(letter);
			n_wr    = 8 + int'(rand_bits(4));
			hdr_pos = int'(rand_bits(3));
			for (int k = 0; k < n_wr; k++) begin
				next_cycle();
				load_i.wr = 1'b1;
				if (k == hdr_pos) begin
					load_i.addr = `MCD_HDR_REGION_ADDR;
					load_i.data = {8'(rand_bits(8)), letter};
				end else begin
					load_i.addr = 25'(rand_bits(25));
					if (load_i.addr == `MCD_HDR_REGION_ADDR) begin
						load_i.addr = '0;
					end
					load_i.data = 16'(rand_bits(16));
				end
			end
			next_cycle();
			load_i.wr = 1'b0;
			repeat (3) next_cycle();
			check(64'(region_o.set), 64'd1, "header region request set");
			check(64'(region_o.region), 64'(exp_region), "header region code");
			load_i.download = 1'b0;
			repeat (3) next_cycle();
			check(64'(region_o.set), 64'd0, "region request release");
		end

		next_cycle();
		$display("PASS: all tests");
		$finish;
	end

	// Run length bound from the test sizes plus margin
	initial begin : watchdog
		#(TOTAL_CYCLES * CLK_PERIOD);
		$display("Timeout: simulation ran longer than %0d clock cycles", TOTAL_CYCLES);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: project.f
+incdir+src
src/mcd_pkg.sv
src/cdd_link.sv
src/cdc_feed.sv
src/kbd_hotkeys.sv
src/region_select.sv
src/mcd_host_glue.sv
verification/tb_mcd_host_glue.sv

// File: Makefile
# Verilator build, run and lint for the CD console host glue

VERILATOR ?= verilator
TOP       := tb_mcd_host_glue
FILELIST  := project.f
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)
LINTFLAGS := --lint-only --timing --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The simulation output is kept in a shell variable and searched for the pass line
run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
